// ==== hdl/jtag_bridge_pkg.sv ====
package jtag_bridge_pkg;

    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;

    // word offsets from BASE_ADDR
    localparam logic [ADDR_W-1:0] STATE_OFS     = 32'd0;
    localparam logic [ADDR_W-1:0] SHIFT_OUT_OFS = 32'd1;  // read only
    localparam logic [ADDR_W-1:0] SHIFT_IN_OFS  = 32'd2;  // write only
    localparam logic [ADDR_W-1:0] CMD_OFS       = 32'd3;  // write only

    // status word layout, one byte per FIFO
    localparam int ST_OUT_FLUSH = 0;
    localparam int ST_OUT_EMPTY = 1;
    localparam int ST_OUT_FULL  = 2;
    localparam int ST_IN_FLUSH  = 8;
    localparam int ST_IN_EMPTY  = 9;
    localparam int ST_IN_FULL   = 10;
    localparam int ST_CMD_FLUSH = 16;
    localparam int ST_CMD_EMPTY = 17;
    localparam int ST_CMD_FULL  = 18;
    localparam int ST_DONE      = 24;

    localparam logic [1:0] BURST_FIXED = 2'd0;
    localparam logic [1:0] BURST_INCR  = 2'd1;
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    localparam logic [3:0] OP_TMS_SEQ = 4'd1;
    localparam logic [3:0] OP_SHIFT   = 4'd2;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [1:0]        burst;
    } aw_t;

    typedef struct packed {
        logic [DATA_W-1:0]   data;
        logic [DATA_W/8-1:0] strb;
        logic                last;
    } w_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;    // beats minus one
        logic [1:0]        burst;
    } ar_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } r_t;

    typedef struct packed {
        logic [3:0]  opcode;
        logic [27:0] cycles;
    } jtag_cmd_t;

    typedef struct packed {
        logic empty;
        logic full;
    } fifo_flags_t;

    typedef struct packed {
        logic tck;
        logic tms;
        logic tdi;
    } jtag_pins_t;

endpackage

// ==== hdl/word_fifo.sv ====
`timescale 1ns/1ps

module word_fifo #(
    parameter int DEPTH_LOG2 = 3
) (
    input  logic                                clk,
    input  logic                                jtag_rstn_sync,
    input  logic                                flush,
    input  logic                                push,
    input  logic [jtag_bridge_pkg::DATA_W-1:0] push_data,
    input  logic                                pop,
    output logic [jtag_bridge_pkg::DATA_W-1:0] head,
    output jtag_bridge_pkg::fifo_flags_t        flags
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    logic [jtag_bridge_pkg::DATA_W-1:0] mem [DEPTH];
    logic [DEPTH_LOG2-1:0]              rd_ptr;
    logic [DEPTH_LOG2-1:0]              wr_ptr;
    logic [DEPTH_LOG2:0]                count;
    logic                               do_push;
    logic                               do_pop;

    assign flags.empty = (count == '0);
    assign flags.full  = count[DEPTH_LOG2];  // count never exceeds DEPTH
    assign do_push     = push && !flags.full;
    assign do_pop      = pop && !flags.empty;
    assign head        = mem[rd_ptr];        // fall-through head word

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // idle or push and pop together
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

endmodule

// ==== hdl/axi_write_port.sv ====
`timescale 1ns/1ps

module axi_write_port #(
    parameter logic [jtag_bridge_pkg::ADDR_W-1:0] BASE_ADDR = 32'h1000_0000
) (
    input  logic                                clk,
    input  logic                                jtag_rstn_sync,
    input  logic                                aw_valid,
    input  jtag_bridge_pkg::aw_t                aw,
    output logic                                aw_ready,
    input  logic                                w_valid,
    input  jtag_bridge_pkg::w_t                 w,
    output logic                                w_ready,
    output logic                                b_valid,
    output logic [1:0]                          b_resp,
    input  logic                                b_ready,
    input  jtag_bridge_pkg::fifo_flags_t        in_flags,
    input  jtag_bridge_pkg::fifo_flags_t        cmd_flags,
    output logic                                in_push,
    output logic [jtag_bridge_pkg::DATA_W-1:0] in_data,
    output logic                                cmd_push,
    output logic [jtag_bridge_pkg::DATA_W-1:0] cmd_data,
    input  jtag_bridge_pkg::fifo_flags_t        out_flags,
    input  logic                                done,
    output logic                                out_flush,
    output logic                                in_flush,
    output logic                                cmd_flush,
    output logic [jtag_bridge_pkg::DATA_W-1:0] status
);

    typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_t;

    wr_state_t                          state;
    logic [jtag_bridge_pkg::ADDR_W-1:0] wr_addr;
    logic [jtag_bridge_pkg::ADDR_W-1:0] wr_ofs;
    logic [1:0]                         wr_burst;
    logic                               err_acc;
    logic                               beat_err;
    logic                               hit_state;
    logic                               hit_in;
    logic                               hit_cmd;
    logic                               w_fire;

    assign wr_ofs    = wr_addr - BASE_ADDR;  // wraps high below the base
    assign beat_err  = (wr_burst != jtag_bridge_pkg::BURST_FIXED
                        && wr_burst != jtag_bridge_pkg::BURST_INCR)
                       || wr_ofs == jtag_bridge_pkg::SHIFT_OUT_OFS
                       || wr_ofs > jtag_bridge_pkg::CMD_OFS;
    assign hit_state = !beat_err && wr_ofs == jtag_bridge_pkg::STATE_OFS;
    assign hit_in    = !beat_err && wr_ofs == jtag_bridge_pkg::SHIFT_IN_OFS;
    assign hit_cmd   = !beat_err && wr_ofs == jtag_bridge_pkg::CMD_OFS;

    assign aw_ready = (state == WR_IDLE);
    assign w_ready  = (state == WR_DATA) && ((hit_in && !in_flags.full)
                      || (hit_cmd && !cmd_flags.full) || hit_state || beat_err);
    assign w_fire   = w_valid && w_ready;
    assign b_valid  = (state == WR_RESP);
    assign b_resp   = err_acc ? jtag_bridge_pkg::RESP_SLVERR : jtag_bridge_pkg::RESP_OKAY;

    assign in_push  = w_fire && hit_in;
    assign in_data  = w.data;
    assign cmd_push = w_fire && hit_cmd;
    assign cmd_data = w.data;

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            state   <= WR_IDLE;
            err_acc <= 1'b0;
        end else begin
            case (state)
                WR_IDLE: if (aw_valid) begin
                    state   <= WR_DATA;
                    err_acc <= 1'b0;               // new burst
                end
                WR_DATA: begin
                    if (w_fire && beat_err)
                        err_acc <= 1'b1;
                    if (w_fire && w.last)
                        state <= WR_RESP;
                end
                default: if (b_ready)
                    state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_valid && aw_ready) begin
            wr_addr  <= aw.addr;
            wr_burst <= aw.burst;
        end else if (w_fire && wr_burst == jtag_bridge_pkg::BURST_INCR) begin
            wr_addr  <= wr_addr + 1'b1;
        end
    end

    // flush bits live for one cycle after the strobed beat
    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            out_flush <= 1'b0;
            in_flush  <= 1'b0;
            cmd_flush <= 1'b0;
        end else begin
            out_flush <= w_fire && hit_state && w.strb[jtag_bridge_pkg::ST_OUT_FLUSH / 8]
                         && w.data[jtag_bridge_pkg::ST_OUT_FLUSH];
            in_flush  <= w_fire && hit_state && w.strb[jtag_bridge_pkg::ST_IN_FLUSH / 8]
                         && w.data[jtag_bridge_pkg::ST_IN_FLUSH];
            cmd_flush <= w_fire && hit_state && w.strb[jtag_bridge_pkg::ST_CMD_FLUSH / 8]
                         && w.data[jtag_bridge_pkg::ST_CMD_FLUSH];
        end
    end

    always_comb begin
        status = '0;
        status[jtag_bridge_pkg::ST_OUT_FLUSH] = out_flush;
        status[jtag_bridge_pkg::ST_OUT_EMPTY] = out_flags.empty;
        status[jtag_bridge_pkg::ST_OUT_FULL]  = out_flags.full;
        status[jtag_bridge_pkg::ST_IN_FLUSH]  = in_flush;
        status[jtag_bridge_pkg::ST_IN_EMPTY]  = in_flags.empty;
        status[jtag_bridge_pkg::ST_IN_FULL]   = in_flags.full;
        status[jtag_bridge_pkg::ST_CMD_FLUSH] = cmd_flush;
        status[jtag_bridge_pkg::ST_CMD_EMPTY] = cmd_flags.empty;
        status[jtag_bridge_pkg::ST_CMD_FULL]  = cmd_flags.full;
        status[jtag_bridge_pkg::ST_DONE]      = done;
    end

endmodule

// ==== hdl/axi_read_port.sv ====
`timescale 1ns/1ps

module axi_read_port #(
    parameter logic [jtag_bridge_pkg::ADDR_W-1:0] BASE_ADDR = 32'h1000_0000
) (
    input  logic                                clk,
    input  logic                                jtag_rstn_sync,
    input  logic                                ar_valid,
    input  jtag_bridge_pkg::ar_t                ar,
    output logic                                ar_ready,
    output logic                                r_valid,
    output jtag_bridge_pkg::r_t                 r,
    input  logic                                r_ready,
    input  logic [jtag_bridge_pkg::DATA_W-1:0] status,
    input  logic [jtag_bridge_pkg::DATA_W-1:0] out_head,
    input  jtag_bridge_pkg::fifo_flags_t        out_flags,
    output logic                                out_pop
);

    typedef enum logic {RD_IDLE, RD_DATA} rd_state_t;

    rd_state_t                          state;
    logic [jtag_bridge_pkg::ADDR_W-1:0] rd_addr;
    logic [jtag_bridge_pkg::ADDR_W-1:0] rd_ofs;
    logic [7:0]                         rd_len;
    logic [1:0]                         rd_burst;
    logic [7:0]                         beat_cnt;
    logic                               beat_err;
    logic                               hit_out;
    logic                               r_fire;

    assign rd_ofs   = rd_addr - BASE_ADDR;
    // only the status and shift-out words can be read
    assign beat_err = (rd_burst != jtag_bridge_pkg::BURST_FIXED
                       && rd_burst != jtag_bridge_pkg::BURST_INCR)
                      || (rd_ofs != jtag_bridge_pkg::STATE_OFS
                          && rd_ofs != jtag_bridge_pkg::SHIFT_OUT_OFS);
    assign hit_out  = !beat_err && rd_ofs == jtag_bridge_pkg::SHIFT_OUT_OFS;

    assign ar_ready = (state == RD_IDLE);
    assign r_valid  = (state == RD_DATA) && (!hit_out || !out_flags.empty);
    assign r_fire   = r_valid && r_ready;
    assign out_pop  = r_fire && hit_out;

    always_comb begin
        r.last = (beat_cnt == rd_len);
        if (beat_err) begin
            r.data = '1;
            r.resp = jtag_bridge_pkg::RESP_SLVERR;
        end else begin
            r.data = hit_out ? out_head : status;
            r.resp = jtag_bridge_pkg::RESP_OKAY;
        end
    end

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            state    <= RD_IDLE;
            beat_cnt <= '0;
        end else if (state == RD_IDLE) begin
            beat_cnt <= '0;
            if (ar_valid)
                state <= RD_DATA;
        end else if (r_fire) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (r.last)
                state <= RD_IDLE;                  // burst ends on last handshake
        end
    end

    always_ff @(posedge clk) begin
        if (ar_valid && ar_ready) begin
            rd_addr  <= ar.addr;
            rd_len   <= ar.len;
            rd_burst <= ar.burst;
        end else if (r_fire && rd_burst == jtag_bridge_pkg::BURST_INCR) begin
            rd_addr  <= rd_addr + 1'b1;
        end
    end

endmodule

// ==== hdl/jtag_shift_engine.sv ====
`timescale 1ns/1ps

module jtag_shift_engine (
    input  logic                                clk,
    input  logic                                jtag_rstn_sync,
    input  jtag_bridge_pkg::jtag_cmd_t          cmd_head,
    input  jtag_bridge_pkg::fifo_flags_t        cmd_flags,
    output logic                                cmd_pop,
    input  logic [jtag_bridge_pkg::DATA_W-1:0] in_head,
    input  jtag_bridge_pkg::fifo_flags_t        in_flags,
    output logic                                in_pop,
    output logic                                out_push,
    output logic [jtag_bridge_pkg::DATA_W-1:0] out_data,
    input  jtag_bridge_pkg::fifo_flags_t        out_flags,
    output jtag_bridge_pkg::jtag_pins_t         jtag,
    input  logic                                tdo,
    output logic                                done
);

    // S_FETCH waits for a data bit, S_LOW and S_HIGH are the two tck phases
    typedef enum logic [1:0] {S_IDLE, S_FETCH, S_LOW, S_HIGH} eng_state_t;

    eng_state_t                         state;
    logic [3:0]                         op;
    logic [27:0]                        remain;      // bits not yet fetched
    logic [4:0]                         bit_idx;     // position in shift-in head
    logic [4:0]                         cap_cnt;
    logic [jtag_bridge_pkg::DATA_W-1:0] cap_word;
    logic                               is_last;     // bit on the pins ends the command
    logic                               cmd_ok;
    logic                               fetch;
    logic                               word_done;
    logic                               out_stall;

    assign cmd_ok  = (cmd_head.opcode == jtag_bridge_pkg::OP_TMS_SEQ
                      || cmd_head.opcode == jtag_bridge_pkg::OP_SHIFT)
                     && cmd_head.cycles != '0;
    assign cmd_pop = (state == S_IDLE) && !cmd_flags.empty;
    assign done    = (state == S_IDLE) && cmd_flags.empty;

    // next bit goes out with the falling edge when data is there
    assign fetch  = (state == S_FETCH || (state == S_HIGH && !is_last)) && !in_flags.empty;
    assign in_pop = fetch && (bit_idx == 5'd31 || remain == 28'd1);

    assign word_done = (op == jtag_bridge_pkg::OP_SHIFT) && (cap_cnt == 5'd31 || is_last);
    assign out_stall = word_done && out_flags.full;
    assign out_push  = (state == S_LOW) && word_done && !out_flags.full;

    always_comb begin
        out_data          = cap_word;
        out_data[cap_cnt] = tdo;                     // bit sampled on this rise
    end

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            state    <= S_IDLE;
            jtag     <= '{tck: 1'b0, tms: 1'b1, tdi: 1'b0};
            op       <= '0;
            remain   <= '0;
            bit_idx  <= '0;
            cap_cnt  <= '0;
            cap_word <= '0;
            is_last  <= 1'b0;
        end else begin
            if (fetch) begin
                bit_idx <= bit_idx + 1'b1;
                remain  <= remain - 1'b1;
                is_last <= (remain == 28'd1);
                if (op == jtag_bridge_pkg::OP_SHIFT) begin
                    jtag.tdi <= in_head[bit_idx];
                    jtag.tms <= (remain == 28'd1);   // leave shift state on last bit
                end else begin
                    jtag.tms <= in_head[bit_idx];
                    jtag.tdi <= 1'b0;
                end
            end
            case (state)
                S_IDLE: if (cmd_pop) begin
                    op       <= cmd_head.opcode;
                    remain   <= cmd_head.cycles;
                    bit_idx  <= '0;
                    cap_cnt  <= '0;
                    cap_word <= '0;
                    if (cmd_ok)
                        state <= S_FETCH;            // unknown opcodes are dropped
                end
                S_FETCH: if (fetch)
                    state <= S_LOW;
                S_LOW: if (!out_stall) begin
                    jtag.tck <= 1'b1;
                    state    <= S_HIGH;
                    if (out_push) begin
                        cap_word <= '0;
                        cap_cnt  <= '0;
                    end else if (op == jtag_bridge_pkg::OP_SHIFT) begin
                        cap_word[cap_cnt] <= tdo;
                        cap_cnt           <= cap_cnt + 1'b1;
                    end
                end
                default: begin
                    jtag.tck <= 1'b0;
                    if (is_last)
                        state <= S_IDLE;
                    else if (fetch)
                        state <= S_LOW;
                    else
                        state <= S_FETCH;            // shift-in FIFO ran dry
                end
            endcase
        end
    end

endmodule

// ==== hdl/jtag_bridge_top.sv ====
`timescale 1ns/1ps

module jtag_bridge_top #(
    parameter logic [jtag_bridge_pkg::ADDR_W-1:0] BASE_ADDR  = 32'h1000_0000,
    parameter int                                 DEPTH_LOG2 = 3
) (
    input  logic                         clk,
    input  logic                         jtag_rstn_sync,
    input  logic                         aw_valid,
    input  jtag_bridge_pkg::aw_t         aw,
    output logic                         aw_ready,
    input  logic                         w_valid,
    input  jtag_bridge_pkg::w_t          w,
    output logic                         w_ready,
    output logic                         b_valid,
    output logic [1:0]                   b_resp,
    input  logic                         b_ready,
    input  logic                         ar_valid,
    input  jtag_bridge_pkg::ar_t         ar,
    output logic                         ar_ready,
    output logic                         r_valid,
    output jtag_bridge_pkg::r_t          r,
    input  logic                         r_ready,
    output jtag_bridge_pkg::jtag_pins_t  jtag,
    input  logic                         tdo
);

    jtag_bridge_pkg::fifo_flags_t       in_flags, cmd_flags, out_flags;
    jtag_bridge_pkg::jtag_cmd_t         cmd_head;
    logic [jtag_bridge_pkg::DATA_W-1:0] in_data, cmd_data, out_data;
    logic [jtag_bridge_pkg::DATA_W-1:0] in_head, out_head, status;
    logic                               in_push, cmd_push, out_push;
    logic                               in_pop, cmd_pop, out_pop;
    logic                               in_flush, cmd_flush, out_flush;
    logic                               done;

    axi_write_port #(.BASE_ADDR(BASE_ADDR)) axi_write_port_inst (
        .clk, .jtag_rstn_sync,
        .aw_valid, .aw, .aw_ready,
        .w_valid, .w, .w_ready,
        .b_valid, .b_resp, .b_ready,
        .in_flags, .cmd_flags,
        .in_push, .in_data, .cmd_push, .cmd_data,
        .out_flags, .done,
        .out_flush, .in_flush, .cmd_flush,
        .status
    );

    axi_read_port #(.BASE_ADDR(BASE_ADDR)) axi_read_port_inst (
        .clk, .jtag_rstn_sync,
        .ar_valid, .ar, .ar_ready,
        .r_valid, .r, .r_ready,
        .status, .out_head, .out_flags, .out_pop
    );

    word_fifo #(.DEPTH_LOG2(DEPTH_LOG2)) shift_in_fifo (
        .clk, .jtag_rstn_sync, .flush(in_flush),
        .push(in_push), .push_data(in_data),
        .pop(in_pop), .head(in_head), .flags(in_flags)
    );

    word_fifo #(.DEPTH_LOG2(DEPTH_LOG2)) cmd_fifo (
        .clk, .jtag_rstn_sync, .flush(cmd_flush),
        .push(cmd_push), .push_data(cmd_data),
        .pop(cmd_pop), .head(cmd_head), .flags(cmd_flags)
    );

    word_fifo #(.DEPTH_LOG2(DEPTH_LOG2)) shift_out_fifo (
        .clk, .jtag_rstn_sync, .flush(out_flush),
        .push(out_push), .push_data(out_data),
        .pop(out_pop), .head(out_head), .flags(out_flags)
    );

    jtag_shift_engine jtag_shift_engine_inst (
        .clk, .jtag_rstn_sync,
        .cmd_head, .cmd_flags, .cmd_pop,
        .in_head, .in_flags, .in_pop,
        .out_push, .out_data, .out_flags,
        .jtag, .tdo, .done
    );

endmodule

// ==== tests/tb_bus_tasks.svh ====
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// one write burst, data taken from wbuf, resp returned from the B channel
task automatic write_burst(input logic [31:0] addr, input logic [1:0] burst,
                           input int beats, input logic [3:0] strb,
                           output logic [1:0] resp);
    @(negedge clk);
    aw_valid = 1'b1;
    aw.addr  = addr;
    aw.burst = burst;
    #1;
    while (!aw_ready) begin
        @(negedge clk);
        #1;
    end
    @(negedge clk);
    aw_valid = 1'b0;
    for (int i = 0; i < beats; i++) begin
        w_valid = 1'b1;
        w.data  = wbuf[i];
        w.strb  = strb;
        w.last  = (i == beats - 1);
        #1;
        while (!w_ready) begin          // FIFO back-pressure
            @(negedge clk);
            #1;
        end
        @(negedge clk);
    end
    w_valid = 1'b0;
    b_ready = 1'b1;
    #1;
    while (!b_valid) begin
        @(negedge clk);
        #1;
    end
    resp = b_resp;
    @(negedge clk);
    b_ready = 1'b0;
endtask

// one read burst of len+1 beats into rdata, rresp and rlast
task automatic read_burst(input logic [31:0] addr, input logic [7:0] len,
                          input logic [1:0] burst);
    @(negedge clk);
    ar_valid = 1'b1;
    ar.addr  = addr;
    ar.len   = len;
    ar.burst = burst;
    #1;
    while (!ar_ready) begin
        @(negedge clk);
        #1;
    end
    @(negedge clk);
    ar_valid = 1'b0;
    r_ready  = 1'b1;
    for (int i = 0; i <= len; i++) begin
        #1;
        while (!r_valid) begin          // shift-out word may not be there yet
            @(negedge clk);
            #1;
        end
        rdata[i] = r.data;
        rresp[i] = r.resp;
        rlast[i] = r.last;
        @(negedge clk);
    end
    r_ready = 1'b0;
endtask

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else begin
        $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        errors++;
        test_errors++;
    end
endtask

task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0)
        $display("test %s passed", name);
    else
        $display("test %s had %0d errors", name, test_errors);
    test_errors = 0;
endtask

`endif

// ==== tests/tb_jtag_bridge.sv ====
`timescale 1ns/1ps

module tb_jtag_bridge;

    localparam logic [31:0] BASE_ADDR    = 32'h1000_0000;
    localparam int          MAX_TMS_BITS = 64;
    localparam int          SHIFT_BITS   = 40;
    localparam int          CYCLE_LIMIT  = (MAX_TMS_BITS + SHIFT_BITS) * 2 + 3000;
    localparam logic [31:0] IDLE_STATUS  = 32'h0102_0202;  // three empties and done

    logic                          clk;
    logic                          jtag_rstn_sync;
    logic                          aw_valid;
    jtag_bridge_pkg::aw_t          aw;
    logic                          aw_ready;
    logic                          w_valid;
    jtag_bridge_pkg::w_t           w;
    logic                          w_ready;
    logic                          b_valid;
    logic [1:0]                    b_resp;
    logic                          b_ready;
    logic                          ar_valid;
    jtag_bridge_pkg::ar_t          ar;
    logic                          ar_ready;
    logic                          r_valid;
    jtag_bridge_pkg::r_t           r;
    logic                          r_ready;
    jtag_bridge_pkg::jtag_pins_t   jtag;
    logic                          tdo;

    logic [7:0]  chain;              // scan chain behind the TAP
    logic        chain_en;           // chain sits in its shift state
    logic        tms_q [$];
    logic        tdi_q [$];
    logic [31:0] wbuf  [16];
    logic [31:0] rdata [16];
    logic [1:0]  rresp [16];
    logic        rlast [16];
    integer      seed;
    int          errors;
    int          test_errors;
    int          checks;
    int          tests_run;
    int          cycles;

    `include "tb_bus_tasks.svh"

    jtag_bridge_top #(
        .BASE_ADDR  (BASE_ADDR),
        .DEPTH_LOG2 (3)
    ) jtag_bridge_top_inst (
        .clk, .jtag_rstn_sync,
        .aw_valid, .aw, .aw_ready,
        .w_valid, .w, .w_ready,
        .b_valid, .b_resp, .b_ready,
        .ar_valid, .ar, .ar_ready,
        .r_valid, .r, .r_ready,
        .jtag, .tdo
    );

    always #20 clk = ~clk;

    // tck is high for exactly one clk, so each falling clk edge with tck high is one pulse
    always @(negedge clk) begin
        if (jtag_rstn_sync && jtag.tck) begin
            tms_q.push_back(jtag.tms);
            tdi_q.push_back(jtag.tdi);
            if (chain_en)
                chain <= {jtag.tdi, chain[7:1]};
        end
    end

    assign tdo = chain[0];

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("no response from the bridge within %0d cycles, run stopped", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic wait_done();
        read_burst(BASE_ADDR, 8'd0, jtag_bridge_pkg::BURST_INCR);
        while (!rdata[0][jtag_bridge_pkg::ST_DONE])
            read_burst(BASE_ADDR, 8'd0, jtag_bridge_pkg::BURST_INCR);
    endtask

    task automatic check_error_read(input logic [31:0] addr, input logic [7:0] len,
                                    input logic [1:0] burst);
        read_burst(addr, len, burst);
        for (int i = 0; i <= len; i++) begin
            check_value("r.resp", rresp[i], jtag_bridge_pkg::RESP_SLVERR);
            check_value("r.data", rdata[i], 32'hffff_ffff);
            check_value("r.last", rlast[i], i == len);
        end
    endtask

    task automatic check_reset_status();
        read_burst(BASE_ADDR, 8'd1, jtag_bridge_pkg::BURST_FIXED);
        for (int i = 0; i < 2; i++) begin
            check_value("r.resp", rresp[i], jtag_bridge_pkg::RESP_OKAY);
            check_value("status", rdata[i], IDLE_STATUS);
            check_value("r.last", rlast[i], i == 1);
        end
        finish_test("reset status");
    endtask

    task automatic check_error_access();
        logic [1:0] resp;
        wbuf[0] = $random(seed);
        write_burst(BASE_ADDR + 1, jtag_bridge_pkg::BURST_INCR, 1, 4'hf, resp);
        check_value("b_resp", resp, jtag_bridge_pkg::RESP_SLVERR);
        write_burst(BASE_ADDR + 6, jtag_bridge_pkg::BURST_FIXED, 1, 4'hf, resp);
        check_value("b_resp", resp, jtag_bridge_pkg::RESP_SLVERR);
        wbuf[0] = 32'h0;
        write_burst(BASE_ADDR, 2'd3, 1, 4'hf, resp);
        check_value("b_resp", resp, jtag_bridge_pkg::RESP_SLVERR);
        check_error_read(BASE_ADDR + 2, 8'd0, jtag_bridge_pkg::BURST_INCR);
        check_error_read(BASE_ADDR + 3, 8'd0, jtag_bridge_pkg::BURST_FIXED);
        check_error_read(BASE_ADDR + 4, 8'd3, jtag_bridge_pkg::BURST_INCR);
        check_error_read(BASE_ADDR, 8'd1, 2'd3);
        // shift-in word, then command word, then off the map
        wbuf[0] = $random(seed);
        wbuf[1] = 32'h0;                // opcode 0 is dropped by the engine
        wbuf[2] = $random(seed);
        write_burst(BASE_ADDR + 2, jtag_bridge_pkg::BURST_INCR, 3, 4'hf, resp);
        check_value("b_resp", resp, jtag_bridge_pkg::RESP_SLVERR);
        finish_test("error access");
    endtask

    task automatic check_fifo_flush();
        logic [1:0] resp;
        for (int i = 0; i < 3; i++)
            wbuf[i] = $random(seed);
        write_burst(BASE_ADDR + 2, jtag_bridge_pkg::BURST_FIXED, 3, 4'hf, resp);
        check_value("b_resp", resp, jtag_bridge_pkg::RESP_OKAY);
        read_burst(BASE_ADDR, 8'd0, jtag_bridge_pkg::BURST_INCR);
        check_value("status", rdata[0], IDLE_STATUS & ~(32'h1 << jtag_bridge_pkg::ST_IN_EMPTY));
        wbuf[0] = 32'h1 << jtag_bridge_pkg::ST_IN_FLUSH;
        write_burst(BASE_ADDR, jtag_bridge_pkg::BURST_INCR, 1, 4'hf, resp);
        check_value("b_resp", resp, jtag_bridge_pkg::RESP_OKAY);
        read_burst(BASE_ADDR, 8'd0, jtag_bridge_pkg::BURST_INCR);
        check_value("status", rdata[0], IDLE_STATUS);
        finish_test("shift-in flush");
    endtask

    task automatic run_tms_seq();
        logic [1:0]                 resp;
        logic [63:0]                bits;
        int                         n;
        jtag_bridge_pkg::jtag_cmd_t cmd;
        n       = 1 + ($unsigned($random(seed)) % MAX_TMS_BITS);
        bits    = {$random(seed), $random(seed)};
        wbuf[0] = bits[31:0];
        wbuf[1] = bits[63:32];
        tms_q.delete();
        tdi_q.delete();
        write_burst(BASE_ADDR + 2, jtag_bridge_pkg::BURST_FIXED, (n + 31) / 32, 4'hf, resp);
        check_value("b_resp", resp, jtag_bridge_pkg::RESP_OKAY);
        cmd.opcode = jtag_bridge_pkg::OP_TMS_SEQ;
        cmd.cycles = 28'(n);
        wbuf[0]    = cmd;
        write_burst(BASE_ADDR + 3, jtag_bridge_pkg::BURST_INCR, 1, 4'hf, resp);
        check_value("b_resp", resp, jtag_bridge_pkg::RESP_OKAY);
        wait_done();
        check_value("tck pulses", tms_q.size(), n);
        for (int i = 0; i < n && i < tms_q.size(); i++) begin
            check_value("jtag.tms", tms_q[i], bits[i]);   // LSB first
            check_value("jtag.tdi", tdi_q[i], 1'b0);
        end
        finish_test("tms sequence");
    endtask

    task automatic run_shift();
        logic [1:0]                 resp;
        logic [63:0]                bits;
        logic [63:0]                exp_bits;
        logic [7:0]                 ref_chain;
        jtag_bridge_pkg::jtag_cmd_t cmd;
        bits      = {$random(seed), $random(seed)};
        ref_chain = chain;
        exp_bits  = '0;
        for (int i = 0; i < SHIFT_BITS; i++) begin
            exp_bits[i] = ref_chain[0];               // old chain contents come out first
            ref_chain   = {bits[i], ref_chain[7:1]};
        end
        wbuf[0] = bits[31:0];
        wbuf[1] = bits[63:32];
        tms_q.delete();
        tdi_q.delete();
        chain_en = 1'b1;
        write_burst(BASE_ADDR + 2, jtag_bridge_pkg::BURST_FIXED, 2, 4'hf, resp);
        check_value("b_resp", resp, jtag_bridge_pkg::RESP_OKAY);
        cmd.opcode = jtag_bridge_pkg::OP_SHIFT;
        cmd.cycles = 28'(SHIFT_BITS);
        wbuf[0]    = cmd;
        write_burst(BASE_ADDR + 3, jtag_bridge_pkg::BURST_INCR, 1, 4'hf, resp);
        check_value("b_resp", resp, jtag_bridge_pkg::RESP_OKAY);
        read_burst(BASE_ADDR + 1, 8'd1, jtag_bridge_pkg::BURST_FIXED);
        check_value("shift-out word 0", rdata[0], exp_bits[31:0]);
        check_value("shift-out word 1", rdata[1], exp_bits[63:32]);
        for (int i = 0; i < 2; i++) begin
            check_value("r.resp", rresp[i], jtag_bridge_pkg::RESP_OKAY);
            check_value("r.last", rlast[i], i == 1);
        end
        wait_done();
        chain_en = 1'b0;
        check_value("tck pulses", tms_q.size(), SHIFT_BITS);
        for (int i = 0; i < SHIFT_BITS && i < tms_q.size(); i++) begin
            check_value("jtag.tdi", tdi_q[i], bits[i]);
            check_value("jtag.tms", tms_q[i], i == SHIFT_BITS - 1);  // exit on last bit
        end
        finish_test("shift");
    endtask

    initial begin
        seed           = 32'he0ed;
        clk            = 1'b0;
        jtag_rstn_sync = 1'b0;
        aw_valid       = 1'b0;
        aw             = '0;
        w_valid        = 1'b0;
        w              = '0;
        b_ready        = 1'b0;
        ar_valid       = 1'b0;
        ar             = '0;
        r_ready        = 1'b0;
        chain          = 8'($random(seed));
        chain_en       = 1'b0;
        errors         = 0;
        test_errors    = 0;
        checks         = 0;
        tests_run      = 0;
        cycles         = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        jtag_rstn_sync = 1'b1;

        check_reset_status();
        check_error_access();
        check_fifo_flush();                // also clears the word left by the error burst
        run_tms_seq();
        run_shift();

        $display("tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+tests
hdl/jtag_bridge_pkg.sv
hdl/word_fifo.sv
hdl/axi_write_port.sv
hdl/axi_read_port.sv
hdl/jtag_shift_engine.sv
hdl/jtag_bridge_top.sv
tests/tb_jtag_bridge.sv

// ==== Bender.yml ====
package:
  name: jtag_bridge

sources:
  - hdl/jtag_bridge_pkg.sv
  - hdl/word_fifo.sv
  - hdl/axi_write_port.sv
  - hdl/axi_read_port.sv
  - hdl/jtag_shift_engine.sv
  - hdl/jtag_bridge_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_jtag_bridge.sv
